//--- src/exu_defs.svh
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// data path width
`define EXU_GRLEN       32

// integer register file
`define EXU_REG_ADDR_W  5
`define EXU_REG_COUNT   32

// bytes per data word, also the pc step
`define EXU_BYTE_LANES  4

`endif

//--- src/exu_pkg.sv
`include "exu_defs.svh"

package exu_pkg;

   typedef logic [`EXU_GRLEN-1:0]      word_t;
   typedef logic [`EXU_REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [`EXU_BYTE_LANES-1:0] wb_sel_t;

   // lui passes operand b through
   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_slt  = 4'd2,
      alu_sltu = 4'd3,
      alu_and  = 4'd4,
      alu_or   = 4'd5,
      alu_nor  = 4'd6,
      alu_xor  = 4'd7,
      alu_sll  = 4'd8,
      alu_srl  = 4'd9,
      alu_sra  = 4'd10,
      alu_lui  = 4'd11
   } alu_op_e;

   typedef enum logic [3:0] {
      bru_beq  = 4'd0,
      bru_bne  = 4'd1,
      bru_blt  = 4'd2,
      bru_bge  = 4'd3,
      bru_bltu = 4'd4,
      bru_bgeu = 4'd5,
      bru_b    = 4'd6,
      bru_bl   = 4'd7,
      bru_jirl = 4'd8
   } bru_op_e;

   typedef enum logic [2:0] {
      lsu_ld_b,
      lsu_ld_bu,
      lsu_ld_h,
      lsu_ld_hu,
      lsu_ld_w,
      lsu_st_b,
      lsu_st_h,
      lsu_st_w
   } lsu_op_e;

   typedef enum logic {
      lsu_idle,
      lsu_bus
   } lsu_state_e;

endpackage

//--- src/exu_regfile.sv
`timescale 1ns/10ps
`include "exu_defs.svh"

module exu_regfile
   import exu_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  reg_addr_t raddr0,
   input  reg_addr_t raddr1,
   output word_t     rdata0,
   output word_t     rdata1,
   input  logic      wen,
   input  reg_addr_t waddr,
   input  word_t     wdata
);

   word_t regs [`EXU_REG_COUNT];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `EXU_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // r0 always reads zero
   assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
   assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

//--- src/exu_alu.sv
`timescale 1ns/10ps
`include "exu_defs.svh"

module exu_alu
   import exu_pkg::*;
(
   input  word_t   a,
   input  word_t   b,
   input  alu_op_e op,
   output word_t   res
);

   localparam int shamt_w = $clog2(`EXU_GRLEN);

   logic [shamt_w-1:0] shamt;
   word_t              sum;
   word_t              diff;

   assign shamt = b[shamt_w-1:0];
   assign sum   = a + b;
   assign diff  = a - b;

   always_comb begin
      unique case (op)
         alu_add:  res = sum;
         alu_sub:  res = diff;
         alu_slt:  res = word_t'($signed(a) < $signed(b));
         alu_sltu: res = word_t'(a < b);
         alu_and:  res = a & b;
         alu_or:   res = a | b;
         alu_nor:  res = ~(a | b);
         alu_xor:  res = a ^ b;
         alu_sll:  res = a << shamt;
         alu_srl:  res = a >> shamt;
         alu_sra:  res = word_t'($signed(a) >>> shamt);
         // immediate already shifted by decode
         alu_lui:  res = b;
         default:  res = '0;
      endcase
   end

endmodule

//--- src/exu_bru.sv
`timescale 1ns/10ps
`include "exu_defs.svh"

module exu_bru
   import exu_pkg::*;
(
   input  logic    valid,
   input  bru_op_e op,
   input  word_t   a,
   input  word_t   b,
   input  word_t   pc,
   input  word_t   offset,
   output word_t   target,
   output logic    taken,
   output word_t   link_pc
);

   logic  cond;
   word_t dest;

   always_comb begin
      unique case (op)
         bru_beq:  cond = (a == b);
         bru_bne:  cond = (a != b);
         bru_blt:  cond = ($signed(a) < $signed(b));
         bru_bge:  cond = ($signed(a) >= $signed(b));
         bru_bltu: cond = (a < b);
         bru_bgeu: cond = (a >= b);
         bru_b, bru_bl, bru_jirl: begin
            cond = 1'b1;
         end
         default:  cond = 1'b0;
      endcase
   end

   // jirl jumps relative to rj, the rest relative to pc
   assign dest = (op == bru_jirl) ? a + offset : pc + offset;

   assign taken   = valid & cond;
   assign target  = valid ? dest : '0;
   assign link_pc = pc + `EXU_BYTE_LANES;

endmodule

//--- src/exu_ecl.sv
`timescale 1ns/10ps

module exu_ecl
   import exu_pkg::*;
(
   input  logic             clk,
   input  logic             rst,

   input  logic             valid_e,
   input  word_t            alu_a_e,
   input  word_t            alu_b_e,
   input  reg_addr_t        rf_target_e,
   input  logic             alu_wen_e,
   input  logic             lsu_valid_e,
   input  exu_pkg::lsu_op_e lsu_op_e,
   input  word_t            imm_shifted_e,
   input  logic             bru_valid_e,
   input  exu_pkg::bru_op_e bru_op_e,

   input  word_t            alu_res,
   input  word_t            link_pc,
   input  logic             stall_req,

   output logic             lsu_req,
   output exu_pkg::lsu_op_e lsu_op,
   output word_t            lsu_base,
   output word_t            lsu_offset,
   output word_t            lsu_wdata,
   output reg_addr_t        lsu_rd,
   output logic             lsu_wen,
   input  word_t            lsu_rdata,
   input  reg_addr_t        lsu_rd_m,
   input  logic             lsu_wen_m,
   input  logic             lsu_finish,

   output logic             rf_wen,
   output reg_addr_t        rf_waddr,
   output word_t            rf_wdata
);

   logic      accept;
   logic      link_op;
   logic      e_wen;
   word_t     e_res;
   logic      m_wen;
   reg_addr_t m_rd;
   word_t     m_res;
   logic      w_wen;
   reg_addr_t w_rd;
   word_t     w_res;

   assign accept  = valid_e & ~stall_req;
   assign link_op = bru_valid_e & (bru_op_e == bru_bl || bru_op_e == bru_jirl);

   // loads write back later through the lsu, plain branches never write
   assign e_wen = accept & alu_wen_e & ~lsu_valid_e & (~bru_valid_e | link_op);
   assign e_res = link_op ? link_pc : alu_res;

   assign lsu_req    = accept & lsu_valid_e;
   assign lsu_op     = lsu_op_e;
   assign lsu_base   = alu_a_e;
   assign lsu_offset = imm_shifted_e;
   assign lsu_wdata  = alu_b_e;
   assign lsu_rd     = rf_target_e;
   assign lsu_wen    = alu_wen_e;

   always_ff @(posedge clk) begin
      if (rst) begin
         m_wen <= 1'b0;
         w_wen <= 1'b0;
      end else begin
         m_wen <= e_wen;
         w_wen <= lsu_finish ? lsu_wen_m : m_wen;
      end
   end

   // M is always a bubble when a load finishes, issue is held during the bus cycle
   always_ff @(posedge clk) begin
      m_rd  <= rf_target_e;
      m_res <= e_res;
      if (lsu_finish) begin
         w_rd  <= lsu_rd_m;
         w_res <= lsu_rdata;
      end else begin
         w_rd  <= m_rd;
         w_res <= m_res;
      end
   end

   assign rf_wen   = w_wen;
   assign rf_waddr = w_rd;
   assign rf_wdata = w_res;

endmodule

//--- src/exu_lsu.sv
`timescale 1ns/10ps
`include "exu_defs.svh"

module exu_lsu
   import exu_pkg::*;
(
   input  logic      clk,
   input  logic      rst,

   input  logic      req,
   input  lsu_op_e   op,
   input  word_t     base,
   input  word_t     offset,
   input  word_t     wdata,
   input  reg_addr_t rd,
   input  logic      wen,

   output word_t     ld_data,
   output reg_addr_t ld_rd,
   output logic      ld_wen,
   output logic      finish,
   output logic      stall_req,

   output logic      data_cyc,
   output logic      data_stb,
   output logic      data_we,
   output word_t     data_adr,
   output wb_sel_t   data_sel,
   output word_t     data_wdata,
   input  word_t     data_rdata,
   input  logic      data_ack
);

   localparam int lane_w = $clog2(`EXU_BYTE_LANES);

   lsu_state_e        state;
   word_t             addr;
   logic [lane_w-1:0] lane;
   wb_sel_t           sel;
   word_t             lane_wdata;
   logic              is_store;
   logic              start;
   logic              done;
   lsu_op_e           op_q;
   logic [lane_w-1:0] lane_q;
   reg_addr_t         rd_q;
   logic              wen_q;
   word_t             rdata_lane;
   word_t             ld_ext;

   assign addr     = base + offset;
   assign lane     = addr[lane_w-1:0];
   assign is_store = op inside {lsu_st_b, lsu_st_h, lsu_st_w};
   assign start    = (state == lsu_idle) && req;
   assign done     = (state == lsu_bus) && data_ack;

   // byte lanes from size and low address bits
   always_comb begin
      case (op)
         lsu_ld_b, lsu_ld_bu, lsu_st_b: begin
            sel        = wb_sel_t'(1) << lane;
            lane_wdata = word_t'(wdata[7:0]) << {lane, 3'b000};
         end
         lsu_ld_h, lsu_ld_hu, lsu_st_h: begin
            sel        = wb_sel_t'(3) << {lane[1], 1'b0};
            lane_wdata = word_t'(wdata[15:0]) << {lane[1], 4'b0000};
         end
         default: begin
            sel        = '1;
            lane_wdata = wdata;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= lsu_idle;
         data_we <= 1'b0;
         finish  <= 1'b0;
         ld_wen  <= 1'b0;
      end else begin
         finish <= done;
         ld_wen <= done & wen_q & ~data_we;
         if (start) begin
            state   <= lsu_bus;
            data_we <= is_store;
         end else if (done) begin
            state   <= lsu_idle;
            data_we <= 1'b0;
         end
      end
   end

   // request held steady for the whole bus cycle
   always_ff @(posedge clk) begin
      if (start) begin
         data_adr   <= {addr[`EXU_GRLEN-1:lane_w], {lane_w{1'b0}}};
         data_sel   <= sel;
         data_wdata <= lane_wdata;
         op_q       <= op;
         lane_q     <= lane;
         rd_q       <= rd;
         wen_q      <= wen;
      end
      if (done) begin
         ld_data <= ld_ext;
         ld_rd   <= rd_q;
      end
   end

   assign rdata_lane = data_rdata >> {lane_q, 3'b000};

   always_comb begin
      case (op_q)
         lsu_ld_b:  ld_ext = {{(`EXU_GRLEN-8){rdata_lane[7]}}, rdata_lane[7:0]};
         lsu_ld_bu: ld_ext = {{(`EXU_GRLEN-8){1'b0}}, rdata_lane[7:0]};
         lsu_ld_h:  ld_ext = {{(`EXU_GRLEN-16){rdata_lane[15]}}, rdata_lane[15:0]};
         lsu_ld_hu: ld_ext = {{(`EXU_GRLEN-16){1'b0}}, rdata_lane[15:0]};
         default:   ld_ext = data_rdata;
      endcase
   end

   assign data_cyc  = (state == lsu_bus);
   assign data_stb  = (state == lsu_bus);
   assign stall_req = (state == lsu_bus);

endmodule

//--- src/cpu7_exu.sv
`timescale 1ns/10ps

module cpu7_exu
   import exu_pkg::*;
(
   input  logic             clk,
   input  logic             rst,

   input  logic             valid_e,
   input  word_t            pc_e,
   input  word_t            alu_a_e,
   input  word_t            alu_b_e,
   input  exu_pkg::alu_op_e alu_op_e,
   input  reg_addr_t        rf_target_e,
   input  logic             alu_wen_e,
   input  logic             lsu_valid_e,
   input  exu_pkg::lsu_op_e lsu_op_e,
   input  word_t            imm_shifted_e,
   input  logic             bru_valid_e,
   input  exu_pkg::bru_op_e bru_op_e,
   input  word_t            bru_offset_e,

   input  reg_addr_t        rs1_d,
   input  reg_addr_t        rs2_d,
   output word_t            rs1_data_d,
   output word_t            rs2_data_d,

   output logic             stall_req,
   output logic             br_taken_e,
   output word_t            brpc_e,

   output logic             data_cyc,
   output logic             data_stb,
   output logic             data_we,
   output word_t            data_adr,
   output wb_sel_t          data_sel,
   output word_t            data_wdata,
   input  word_t            data_rdata,
   input  logic             data_ack
);

   word_t            alu_res;
   word_t            link_pc;
   logic             lsu_req;
   exu_pkg::lsu_op_e lsu_op;
   word_t            lsu_base;
   word_t            lsu_offset;
   word_t            lsu_wdata;
   reg_addr_t        lsu_rd;
   logic             lsu_wen;
   word_t            lsu_rdata;
   reg_addr_t        lsu_rd_m;
   logic             lsu_wen_m;
   logic             lsu_finish;
   logic             rf_wen;
   reg_addr_t        rf_waddr;
   word_t            rf_wdata;

   exu_ecl i_ecl (
      .clk          (clk),
      .rst          (rst),
      .valid_e      (valid_e),
      .alu_a_e      (alu_a_e),
      .alu_b_e      (alu_b_e),
      .rf_target_e  (rf_target_e),
      .alu_wen_e    (alu_wen_e),
      .lsu_valid_e  (lsu_valid_e),
      .lsu_op_e     (lsu_op_e),
      .imm_shifted_e(imm_shifted_e),
      .bru_valid_e  (bru_valid_e),
      .bru_op_e     (bru_op_e),
      .alu_res      (alu_res),
      .link_pc      (link_pc),
      .stall_req    (stall_req),
      .lsu_req      (lsu_req),
      .lsu_op       (lsu_op),
      .lsu_base     (lsu_base),
      .lsu_offset   (lsu_offset),
      .lsu_wdata    (lsu_wdata),
      .lsu_rd       (lsu_rd),
      .lsu_wen      (lsu_wen),
      .lsu_rdata    (lsu_rdata),
      .lsu_rd_m     (lsu_rd_m),
      .lsu_wen_m    (lsu_wen_m),
      .lsu_finish   (lsu_finish),
      .rf_wen       (rf_wen),
      .rf_waddr     (rf_waddr),
      .rf_wdata     (rf_wdata)
   );

   exu_alu i_alu (
      .a  (alu_a_e),
      .b  (alu_b_e),
      .op (alu_op_e),
      .res(alu_res)
   );

   // branch outputs only for a presented branch
   exu_bru i_bru (
      .valid  (valid_e & bru_valid_e),
      .op     (bru_op_e),
      .a      (alu_a_e),
      .b      (alu_b_e),
      .pc     (pc_e),
      .offset (bru_offset_e),
      .target (brpc_e),
      .taken  (br_taken_e),
      .link_pc(link_pc)
   );

   exu_lsu i_lsu (
      .clk       (clk),
      .rst       (rst),
      .req       (lsu_req),
      .op        (lsu_op),
      .base      (lsu_base),
      .offset    (lsu_offset),
      .wdata     (lsu_wdata),
      .rd        (lsu_rd),
      .wen       (lsu_wen),
      .ld_data   (lsu_rdata),
      .ld_rd     (lsu_rd_m),
      .ld_wen    (lsu_wen_m),
      .finish    (lsu_finish),
      .stall_req (stall_req),
      .data_cyc  (data_cyc),
      .data_stb  (data_stb),
      .data_we   (data_we),
      .data_adr  (data_adr),
      .data_sel  (data_sel),
      .data_wdata(data_wdata),
      .data_rdata(data_rdata),
      .data_ack  (data_ack)
   );

   exu_regfile i_regfile (
      .clk   (clk),
      .rst   (rst),
      .raddr0(rs1_d),
      .raddr1(rs2_d),
      .rdata0(rs1_data_d),
      .rdata1(rs2_data_d),
      .wen   (rf_wen),
      .waddr (rf_waddr),
      .wdata (rf_wdata)
   );

endmodule

//--- sim/tb_exu_model.svh
`ifndef TB_EXU_MODEL_SVH
`define TB_EXU_MODEL_SVH

localparam int mem_words = 256;

word_t model_regs [`EXU_REG_COUNT];
word_t model_mem  [mem_words];

// odd multiplier, so every address bit changes the word
function automatic word_t fill_word(int idx);
   return word_t'(idx) * 32'h9e37_79b1 ^ 32'h0f1e_2d3c;
endfunction

task automatic reg_write(input reg_addr_t rd, input word_t value);
   // r0 stays zero
   if (rd != '0)
      model_regs[rd] = value;
endtask

function automatic word_t alu_result(alu_op_e op, word_t a, word_t b);
   case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_and:  return a & b;
      alu_or:   return a | b;
      alu_nor:  return ~(a | b);
      alu_xor:  return a ^ b;
      alu_sll:  return a << b[4:0];
      alu_srl:  return a >> b[4:0];
      alu_sra:  return word_t'($signed(a) >>> b[4:0]);
      alu_lui:  return b;
      default:  return '0;
   endcase
endfunction

function automatic logic branch_cond(bru_op_e op, word_t a, word_t b);
   case (op)
      bru_beq:  return a == b;
      bru_bne:  return a != b;
      bru_blt:  return $signed(a) < $signed(b);
      bru_bge:  return $signed(a) >= $signed(b);
      bru_bltu: return a < b;
      bru_bgeu: return a >= b;
      bru_b, bru_bl, bru_jirl: return 1'b1;
      default:  return 1'b0;
   endcase
endfunction

function automatic word_t jump_target(bru_op_e op, word_t a, word_t pc, word_t offset);
   return (op == bru_jirl) ? a + offset : pc + offset;
endfunction

// lane is the low two address bits
function automatic wb_sel_t lane_sel(lsu_op_e op, logic [1:0] lane);
   case (op)
      lsu_ld_b, lsu_ld_bu, lsu_st_b: return wb_sel_t'(1) << lane;
      lsu_ld_h, lsu_ld_hu, lsu_st_h: return lane[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
   endcase
endfunction

function automatic word_t byte_mask(wb_sel_t sel);
   word_t m;
   for (int i = 0; i < `EXU_BYTE_LANES; i++)
      m[8*i +: 8] = {8{sel[i]}};
   return m;
endfunction

function automatic word_t merge_lanes(word_t old, word_t data, wb_sel_t sel);
   return (old & ~byte_mask(sel)) | (data & byte_mask(sel));
endfunction

// store data copied to every lane, the select picks the right one
function automatic word_t store_lanes(lsu_op_e op, word_t data);
   case (op)
      lsu_st_b: return {4{data[7:0]}};
      lsu_st_h: return {2{data[15:0]}};
      default:  return data;
   endcase
endfunction

function automatic word_t load_value(lsu_op_e op, word_t w, logic [1:0] lane);
   logic [7:0]  byte_v;
   logic [15:0] half_v;
   byte_v = w[8*lane +: 8];
   half_v = lane[1] ? w[31:16] : w[15:0];
   case (op)
      lsu_ld_b:  return {{24{byte_v[7]}}, byte_v};
      lsu_ld_bu: return {24'b0, byte_v};
      lsu_ld_h:  return {{16{half_v[15]}}, half_v};
      lsu_ld_hu: return {16'b0, half_v};
      default:   return w;
   endcase
endfunction

`endif

//--- sim/tb_exu.sv
`timescale 1ns/10ps
`include "exu_defs.svh"

module tb_exu
   import exu_pkg::*;
();

   localparam int clk_period    = 20;
   localparam int reset_cycles  = 8;
   localparam int n_instr       = 400;
   localparam int max_ack_delay = 5;

   logic      clk;
   logic      rst;
   logic      valid_e;
   word_t     pc_e;
   word_t     alu_a_e;
   word_t     alu_b_e;
   alu_op_e   alu_op;
   reg_addr_t rf_target_e;
   logic      alu_wen_e;
   logic      lsu_valid_e;
   lsu_op_e   lsu_op;
   word_t     imm_shifted_e;
   logic      bru_valid_e;
   bru_op_e   bru_op;
   word_t     bru_offset_e;
   reg_addr_t rs1_d;
   reg_addr_t rs2_d;
   word_t     rs1_data_d;
   word_t     rs2_data_d;
   logic      stall_req;
   logic      br_taken_e;
   word_t     brpc_e;
   logic      data_cyc;
   logic      data_stb;
   logic      data_we;
   word_t     data_adr;
   wb_sel_t   data_sel;
   word_t     data_wdata;
   word_t     data_rdata;
   logic      data_ack;

   integer    seed;
   int        issued;
   int        mem_issued;
   int        bus_cycles;
   reg_addr_t rd_a;
   reg_addr_t rd_b;
   logic      mem_a;

   `include "tb_exu_model.svh"

   // expected bus cycles in issue order
   word_t   exp_adr_q[$];
   wb_sel_t exp_sel_q[$];
   logic    exp_we_q[$];
   word_t   exp_wdata_q[$];
   int      delay_q[$];
   word_t   bus_mem [mem_words];

   logic    busy;
   int      wait_left;
   word_t   cur_adr;
   wb_sel_t cur_sel;
   logic    cur_we;
   word_t   cur_wdata;

   cpu7_exu i_dut (
      .clk          (clk),
      .rst          (rst),
      .valid_e      (valid_e),
      .pc_e         (pc_e),
      .alu_a_e      (alu_a_e),
      .alu_b_e      (alu_b_e),
      .alu_op_e     (alu_op),
      .rf_target_e  (rf_target_e),
      .alu_wen_e    (alu_wen_e),
      .lsu_valid_e  (lsu_valid_e),
      .lsu_op_e     (lsu_op),
      .imm_shifted_e(imm_shifted_e),
      .bru_valid_e  (bru_valid_e),
      .bru_op_e     (bru_op),
      .bru_offset_e (bru_offset_e),
      .rs1_d        (rs1_d),
      .rs2_d        (rs2_d),
      .rs1_data_d   (rs1_data_d),
      .rs2_data_d   (rs2_data_d),
      .stall_req    (stall_req),
      .br_taken_e   (br_taken_e),
      .brpc_e       (brpc_e),
      .data_cyc     (data_cyc),
      .data_stb     (data_stb),
      .data_we      (data_we),
      .data_adr     (data_adr),
      .data_sel     (data_sel),
      .data_wdata   (data_wdata),
      .data_rdata   (data_rdata),
      .data_ack     (data_ack)
   );

   initial clk = 1'b0;
   always #(clk_period/2) clk = ~clk;

   task automatic abort_run(input string what);
      $display("%s", what);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic word_check(input string name, input word_t exp, input word_t act);
      if (act !== exp)
         abort_run($sformatf("error %s expected %h got %h", name, exp, act));
   endtask

   task automatic bit_check(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("error %s expected %h got %h", name, exp, act));
   endtask

   task automatic sel_check(input string name, input wb_sel_t exp, input wb_sel_t act);
      if (act !== exp)
         abort_run($sformatf("error %s expected %h got %h", name, exp, act));
   endtask

   function automatic int rand_below(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // slave acks after the drawn delay
   always @(negedge clk) begin
      if (data_ack) begin
         data_ack = 1'b0;
         bit_check("data_cyc", 1'b0, data_cyc);
         bit_check("data_stb", 1'b0, data_stb);
         bit_check("stall_req", 1'b0, stall_req);
      end else if (data_cyc) begin
         if (!busy) begin
            if (exp_adr_q.size() == 0)
               abort_run("a bus cycle started with no memory instruction pending");
            busy      = 1'b1;
            cur_adr   = exp_adr_q.pop_front();
            cur_sel   = exp_sel_q.pop_front();
            cur_we    = exp_we_q.pop_front();
            cur_wdata = exp_wdata_q.pop_front();
            wait_left = delay_q.pop_front();
         end
         bit_check("data_stb", 1'b1, data_stb);
         bit_check("stall_req", 1'b1, stall_req);
         bit_check("data_we", cur_we, data_we);
         word_check("data_adr", cur_adr, data_adr);
         sel_check("data_sel", cur_sel, data_sel);
         if (cur_we)
            word_check("data_wdata", cur_wdata & byte_mask(cur_sel),
                       data_wdata & byte_mask(cur_sel));
         if (wait_left == 0) begin
            if (cur_we)
               bus_mem[cur_adr[9:2]] = merge_lanes(bus_mem[cur_adr[9:2]], data_wdata, cur_sel);
            else
               data_rdata = bus_mem[cur_adr[9:2]];
            data_ack   = 1'b1;
            busy       = 1'b0;
            bus_cycles = bus_cycles + 1;
         end else begin
            wait_left = wait_left - 1;
         end
      end else if (busy) begin
         abort_run("data_cyc dropped before the slave gave ack");
      end
   end

   // starts at a falling edge and returns at the one after acceptance
   task automatic run_one(output reg_addr_t rd, output logic is_mem);
      int      kind;
      word_t   a;
      word_t   b;
      word_t   pc;
      word_t   offset;
      word_t   addr;
      alu_op_e aop;
      bru_op_e bop;
      lsu_op_e mop;
      logic    is_store;
      logic    wen;
      logic    exp_taken;
      word_t   exp_target;
      kind       = rand_below(4);
      a          = $random(seed);
      b          = (rand_below(4) == 0) ? a : $random(seed);
      pc         = $random(seed) & 32'hffff_fffc;
      offset     = $random(seed) & 32'hffff_fffc;
      rd         = reg_addr_t'(rand_below(`EXU_REG_COUNT));
      aop        = alu_op_e'(rand_below(12));
      bop        = bru_op_e'(rand_below(9));
      mop        = lsu_op_e'(rand_below(8));
      is_mem     = (kind >= 2);
      is_store   = (mop == lsu_st_b || mop == lsu_st_h || mop == lsu_st_w);
      exp_taken  = 1'b0;
      exp_target = '0;
      wen        = 1'b1;
      if (kind == 0) begin
         reg_write(rd, alu_result(aop, a, b));
      end else if (kind == 1) begin
         exp_taken  = branch_cond(bop, a, b);
         exp_target = jump_target(bop, a, pc, offset);
         wen        = (bop == bru_bl || bop == bru_jirl);
         if (wen)
            reg_write(rd, pc + 4);
      end else begin
         addr = word_t'(rand_below(mem_words * 4));
         if (mop == lsu_ld_h || mop == lsu_ld_hu || mop == lsu_st_h)
            addr[0] = 1'b0;
         if (mop == lsu_ld_w || mop == lsu_st_w)
            addr[1:0] = 2'b00;
         offset = word_t'(rand_below(4096) - 2048);
         a      = addr - offset;
         wen    = !is_store;
         exp_adr_q.push_back(addr & 32'hffff_fffc);
         exp_sel_q.push_back(lane_sel(mop, addr[1:0]));
         exp_we_q.push_back(is_store);
         exp_wdata_q.push_back(store_lanes(mop, b));
         delay_q.push_back(rand_below(max_ack_delay + 1));
         if (is_store)
            model_mem[addr[9:2]] = merge_lanes(model_mem[addr[9:2]], store_lanes(mop, b),
                                               lane_sel(mop, addr[1:0]));
         else
            reg_write(rd, load_value(mop, model_mem[addr[9:2]], addr[1:0]));
         mem_issued = mem_issued + 1;
      end
      valid_e       = 1'b1;
      pc_e          = pc;
      alu_a_e       = a;
      alu_b_e       = b;
      alu_op        = aop;
      rf_target_e   = rd;
      alu_wen_e     = wen;
      lsu_valid_e   = is_mem;
      lsu_op        = mop;
      imm_shifted_e = offset;
      bru_valid_e   = (kind == 1);
      bru_op        = bop;
      bru_offset_e  = offset;
      #(clk_period/4);
      bit_check("br_taken_e", exp_taken, br_taken_e);
      word_check("brpc_e", exp_target, brpc_e);
      // held while a bus cycle is open
      while (stall_req) begin
         @(negedge clk);
         #(clk_period/4);
      end
      @(negedge clk);
      valid_e     = 1'b0;
      lsu_valid_e = 1'b0;
      bru_valid_e = 1'b0;
   endtask

   // wait for an idle bus, then three edges so the last result reaches the register file
   task automatic settle();
      while (stall_req)
         @(negedge clk);
      repeat (3) @(posedge clk);
   endtask

   task automatic read_regs(input reg_addr_t r1, input reg_addr_t r2);
      @(negedge clk);
      rs1_d = r1;
      rs2_d = r2;
      #(clk_period/4);
      word_check("rs1_data_d", model_regs[r1], rs1_data_d);
      word_check("rs2_data_d", model_regs[r2], rs2_data_d);
   endtask

   initial begin
      #((n_instr * (max_ack_delay + 6) + reset_cycles) * clk_period);
      abort_run("timeout, the test did not finish in time");
   end

   initial begin
      seed          = 32'h3e4a_f5f9;
      rst           = 1'b1;
      valid_e       = 1'b0;
      pc_e          = '0;
      alu_a_e       = '0;
      alu_b_e       = '0;
      alu_op        = alu_add;
      rf_target_e   = '0;
      alu_wen_e     = 1'b0;
      lsu_valid_e   = 1'b0;
      lsu_op        = lsu_ld_w;
      imm_shifted_e = '0;
      bru_valid_e   = 1'b0;
      bru_op        = bru_beq;
      bru_offset_e  = '0;
      rs1_d         = '0;
      rs2_d         = '0;
      data_rdata    = '0;
      data_ack      = 1'b0;
      busy          = 1'b0;
      wait_left     = 0;
      bus_cycles    = 0;
      mem_issued    = 0;
      for (int i = 0; i < `EXU_REG_COUNT; i++)
         model_regs[i] = '0;
      for (int i = 0; i < mem_words; i++) begin
         model_mem[i] = fill_word(i);
         bus_mem[i]   = fill_word(i);
      end
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      #(clk_period/4);
      bit_check("stall_req", 1'b0, stall_req);
      bit_check("data_cyc", 1'b0, data_cyc);
      bit_check("data_stb", 1'b0, data_stb);
      bit_check("data_we", 1'b0, data_we);
      bit_check("br_taken_e", 1'b0, br_taken_e);
      for (int i = 0; i < `EXU_REG_COUNT; i++)
         read_regs(reg_addr_t'(i), reg_addr_t'(`EXU_REG_COUNT - 1 - i));

      issued = 0;
      while (issued < n_instr) begin
         @(negedge clk);
         run_one(rd_a, mem_a);
         issued = issued + 1;
         if (mem_a && rand_below(2) == 1) begin
            // presented while the first one still holds the bus
            run_one(rd_b, mem_a);
            issued = issued + 1;
            settle();
            read_regs(rd_a, rd_b);
            read_regs(rd_b, rd_a);
         end else begin
            settle();
            read_regs(rd_a, rd_a);
         end
      end

      if (bus_cycles != mem_issued) begin
         abort_run($sformatf("error bus_cycles expected %h got %h", mem_issued, bus_cycles));
      end else begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

//--- sim.f
+incdir+src
+incdir+sim
src/exu_pkg.sv
src/exu_regfile.sv
src/exu_alu.sv
src/exu_bru.sv
src/exu_ecl.sv
src/exu_lsu.sv
src/cpu7_exu.sv
sim/tb_exu.sv

//--- Bender.yml
package:
  name: cpu7_exu

sources:
  - include_dirs:
      - src
    files:
      - src/exu_pkg.sv
      - src/exu_regfile.sv
      - src/exu_alu.sv
      - src/exu_bru.sv
      - src/exu_ecl.sv
      - src/exu_lsu.sv
      - src/cpu7_exu.sv
  - target: simulation
    include_dirs:
      - src
      - sim
    files:
      - sim/tb_exu.sv
